// ==== design/mini_mcu_pkg.sv ====
/*
  shared definitions for the mini MCU subsystem
  bus widths, memory map and register offsets, pass code,
  decoded slave enum and arbiter state enum
*/
`default_nettype none

package mini_mcu_pkg;

  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int SEL_W  = 4;

  // memory map
  localparam logic [ADDR_W-1:0] RAM_BASE    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] TIMER_BASE  = 32'h1500_0000;
  localparam logic [ADDR_W-1:0] EXIT_BASE   = 32'h2000_0000;
  // timer and exit windows hold two words each
  localparam logic [ADDR_W-1:0] PERIPH_SPAN = 32'h0000_0008;

  // register offsets inside a peripheral window
  localparam logic [2:0] TMR_COUNT_OFF   = 3'h0;
  localparam logic [2:0] TMR_CMP_OFF     = 3'h4;
  localparam logic [2:0] EXIT_STATUS_OFF = 3'h0;
  localparam logic [2:0] EXIT_VALUE_OFF  = 3'h4;

  // anything else written to the status register means fail
  localparam logic [DATA_W-1:0] TEST_PASS_CODE = 32'd123456789;

  typedef enum logic [1:0] {
    SLAVE_RAM,
    SLAVE_TIMER,
    SLAVE_EXIT,
    SLAVE_NONE
  } slave_sel_e;

  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_CORE,
    ARB_DEBUG
  } arb_state_e;

endpackage

`default_nettype wire

// ==== design/bus_arbiter.sv ====
/*
  round-robin arbiter between the core and debug Wishbone masters
  grant held for a whole bus cycle, response routed to the owner only
*/
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic                             clk_i,
  input  logic                             reset_i,

  input  logic                             core_cyc_i,
  input  logic                             core_stb_i,
  input  logic                             core_we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  core_adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  core_dat_i,
  input  logic [mini_mcu_pkg::SEL_W-1:0]   core_sel_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  core_dat_o,
  output logic                             core_ack_o,

  input  logic                             dbg_cyc_i,
  input  logic                             dbg_stb_i,
  input  logic                             dbg_we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  dbg_adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  dbg_dat_i,
  input  logic [mini_mcu_pkg::SEL_W-1:0]   dbg_sel_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  dbg_dat_o,
  output logic                             dbg_ack_o,

  output logic                             bus_cyc_o,
  output logic                             bus_stb_o,
  output logic                             bus_we_o,
  output logic [mini_mcu_pkg::ADDR_W-1:0]  bus_adr_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]  bus_dat_o,
  output logic [mini_mcu_pkg::SEL_W-1:0]   bus_sel_o,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  bus_dat_i,
  input  logic                             bus_ack_i
);

  import mini_mcu_pkg::*;

  arb_state_e state_q;
  arb_state_e grant;
  logic       last_dbg_q;

  // from idle the grant is taken in the same cycle, afterwards state_q holds it
  always_comb begin
    grant = state_q;
    if (state_q == ARB_IDLE) begin
      if (core_cyc_i && dbg_cyc_i) begin
        // tie goes to whoever did not own the bus last
        grant = last_dbg_q ? ARB_CORE : ARB_DEBUG;
      end else if (core_cyc_i) begin
        grant = ARB_CORE;
      end else if (dbg_cyc_i) begin
        grant = ARB_DEBUG;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q    <= ARB_IDLE;
      last_dbg_q <= 1'b1;
    end else begin
      // owner dropping cyc sends us back to idle on the next cycle
      state_q <= bus_cyc_o ? grant : ARB_IDLE;
      if (state_q == ARB_IDLE && grant != ARB_IDLE) begin
        last_dbg_q <= (grant == ARB_DEBUG);
      end
    end
  end

  // forward the owner's request
  always_comb begin
    bus_cyc_o = 1'b0;
    bus_stb_o = 1'b0;
    bus_we_o  = 1'b0;
    bus_adr_o = '0;
    bus_dat_o = '0;
    bus_sel_o = '0;
    case (grant)
      ARB_CORE: begin
        bus_cyc_o = core_cyc_i;
        bus_stb_o = core_cyc_i && core_stb_i;
        bus_we_o  = core_we_i;
        bus_adr_o = core_adr_i;
        bus_dat_o = core_dat_i;
        bus_sel_o = core_sel_i;
      end
      ARB_DEBUG: begin
        bus_cyc_o = dbg_cyc_i;
        bus_stb_o = dbg_cyc_i && dbg_stb_i;
        bus_we_o  = dbg_we_i;
        bus_adr_o = dbg_adr_i;
        bus_dat_o = dbg_dat_i;
        bus_sel_o = dbg_sel_i;
      end
      default: begin
      end
    endcase
  end

  // response only reaches the owner
  assign core_ack_o = (grant == ARB_CORE) && bus_ack_i;
  assign dbg_ack_o  = (grant == ARB_DEBUG) && bus_ack_i;
  assign core_dat_o = (grant == ARB_CORE) ? bus_dat_i : '0;
  assign dbg_dat_o  = (grant == ARB_DEBUG) ? bus_dat_i : '0;

endmodule

`default_nettype wire

// ==== design/slave_decoder.sv ====
/*
  address decoder for the shared bus
  per-slave strobes, response mux, zero-data ack for unmapped addresses
*/
`timescale 1ns/1ps
`default_nettype none

module slave_decoder #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             bus_stb_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  bus_adr_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  bus_dat_o,
  output logic                             bus_ack_o,

  output logic                             ram_stb_o,
  output logic                             tmr_stb_o,
  output logic                             exit_stb_o,

  input  logic [mini_mcu_pkg::DATA_W-1:0]  ram_dat_i,
  input  logic                             ram_ack_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  tmr_dat_i,
  input  logic                             tmr_ack_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  exit_dat_i,
  input  logic                             exit_ack_i
);

  import mini_mcu_pkg::*;

  localparam logic [ADDR_W-1:0] RAM_BYTES = ADDR_W'(4 * RAM_WORDS);

  slave_sel_e sel_d;
  slave_sel_e sel_q;
  logic       none_ack_q;

  always_comb begin
    if ((bus_adr_i - RAM_BASE) < RAM_BYTES) begin
      sel_d = SLAVE_RAM;
    end else if ((bus_adr_i - TIMER_BASE) < PERIPH_SPAN) begin
      sel_d = SLAVE_TIMER;
    end else if ((bus_adr_i - EXIT_BASE) < PERIPH_SPAN) begin
      sel_d = SLAVE_EXIT;
    end else begin
      sel_d = SLAVE_NONE;
    end
  end

  assign ram_stb_o  = bus_stb_i && (sel_d == SLAVE_RAM);
  assign tmr_stb_o  = bus_stb_i && (sel_d == SLAVE_TIMER);
  assign exit_stb_o = bus_stb_i && (sel_d == SLAVE_EXIT);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sel_q      <= SLAVE_NONE;
      none_ack_q <= 1'b0;
    end else begin
      // keep the issuing selection through the ack cycle
      if (bus_stb_i && !bus_ack_o) begin
        sel_q <= sel_d;
      end
      none_ack_q <= bus_stb_i && (sel_d == SLAVE_NONE) && !none_ack_q;
    end
  end

  always_comb begin
    case (sel_q)
      SLAVE_RAM: begin
        bus_dat_o = ram_dat_i;
        bus_ack_o = ram_ack_i;
      end
      SLAVE_TIMER: begin
        bus_dat_o = tmr_dat_i;
        bus_ack_o = tmr_ack_i;
      end
      SLAVE_EXIT: begin
        bus_dat_o = exit_dat_i;
        bus_ack_o = exit_ack_i;
      end
      default: begin
        bus_dat_o = '0;
        bus_ack_o = none_ack_q;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== design/sram.sv ====
/*
  word-addressed RAM with byte-select writes
  registered read data and a one-cycle ack per access
*/
`timescale 1ns/1ps
`default_nettype none

module sram #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  dat_i,
  input  logic [mini_mcu_pkg::SEL_W-1:0]   sel_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  dat_o,
  output logic                             ack_o
);

  import mini_mcu_pkg::*;

  localparam int IDX_W = $clog2(RAM_WORDS);

  logic [DATA_W-1:0] mem [RAM_WORDS];
  logic [IDX_W-1:0]  word_idx;
  logic              ack_q;
  logic              access;

  assign word_idx = adr_i[IDX_W+1:2];
  // no access in the ack cycle, so a held strobe gives one ack
  assign access   = stb_i && !ack_q;

  always_ff @(posedge clk_i) begin
    if (access && we_i) begin
      for (int b = 0; b < SEL_W; b++) begin
        if (sel_i[b]) begin
          mem[word_idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
    if (access) begin
      dat_o <= mem[word_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= access;
    end
  end

  assign ack_o = ack_q;

endmodule

`default_nettype wire

// ==== design/timer_irq.sv ====
/*
  free-running 32-bit timer with a compare register
  level interrupt on a nonzero compare match, cleared by a compare write
*/
`timescale 1ns/1ps
`default_nettype none

module timer_irq (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  dat_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  dat_o,
  output logic                             ack_o,
  output logic                             timer_irq_o
);

  import mini_mcu_pkg::*;

  logic [DATA_W-1:0] count_q;
  logic [DATA_W-1:0] cmp_q;
  logic              ack_q;
  logic              irq_q;
  logic              access;
  logic              cmp_wr;

  assign access = stb_i && !ack_q;
  assign cmp_wr = access && we_i && (adr_i[2:0] == TMR_CMP_OFF);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      count_q <= '0;
      cmp_q   <= '0;
      ack_q   <= 1'b0;
      irq_q   <= 1'b0;
    end else begin
      count_q <= count_q + DATA_W'(1);
      ack_q   <= access;
      if (cmp_wr) begin
        cmp_q <= dat_i;
        irq_q <= 1'b0;
      end else if (cmp_q != '0 && count_q == cmp_q) begin
        // zero compare means disarmed
        irq_q <= 1'b1;
      end
    end
  end

  // counter is read-only, writes to it are dropped
  always_ff @(posedge clk_i) begin
    if (access) begin
      case (adr_i[2:0])
        TMR_COUNT_OFF: dat_o <= count_q;
        TMR_CMP_OFF:   dat_o <= cmp_q;
        default:       dat_o <= '0;
      endcase
    end
  end

  assign ack_o       = ack_q;
  assign timer_irq_o = irq_q;

endmodule

`default_nettype wire

// ==== design/exit_ctrl.sv ====
/*
  test status and exit value registers
  sticky pass/fail flags, exit value with one-cycle valid pulse
*/
`timescale 1ns/1ps
`default_nettype none

module exit_ctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             stb_i,
  input  logic                             we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  dat_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  dat_o,
  output logic                             ack_o,
  output logic                             tests_passed_o,
  output logic                             tests_failed_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]  exit_value_o,
  output logic                             exit_valid_o
);

  import mini_mcu_pkg::*;

  logic [DATA_W-1:0] status_q;
  logic [DATA_W-1:0] value_q;
  logic              passed_q;
  logic              failed_q;
  logic              valid_q;
  logic              ack_q;
  logic              access;

  assign access = stb_i && !ack_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      status_q <= '0;
      value_q  <= '0;
      passed_q <= 1'b0;
      failed_q <= 1'b0;
      valid_q  <= 1'b0;
      ack_q    <= 1'b0;
    end else begin
      ack_q   <= access;
      valid_q <= access && we_i && (adr_i[2:0] == EXIT_VALUE_OFF);
      if (access && we_i && adr_i[2:0] == EXIT_STATUS_OFF) begin
        status_q <= dat_i;
        // first verdict sticks until reset
        if (!passed_q && !failed_q) begin
          passed_q <= (dat_i == TEST_PASS_CODE);
          failed_q <= (dat_i != TEST_PASS_CODE);
        end
      end
      if (access && we_i && adr_i[2:0] == EXIT_VALUE_OFF) begin
        value_q <= dat_i;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= (adr_i[2:0] == EXIT_VALUE_OFF) ? value_q : status_q;
    end
  end

  assign ack_o          = ack_q;
  assign tests_passed_o = passed_q;
  assign tests_failed_o = failed_q;
  assign exit_value_o   = value_q;
  assign exit_valid_o   = valid_q;

endmodule

`default_nettype wire

// ==== design/core_v_mini_mcu.sv ====
/*
  mini MCU memory and peripheral subsystem top level
  core and debug Wishbone masters share one bus through an arbiter,
  decoder feeds the RAM, timer and exit controller
*/
`timescale 1ns/1ps
`default_nettype none

module core_v_mini_mcu #(
  parameter int RAM_WORDS = 1024
) (
  input  logic                             clk_i,
  input  logic                             reset_i,

  input  logic                             core_cyc_i,
  input  logic                             core_stb_i,
  input  logic                             core_we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  core_adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  core_dat_i,
  input  logic [mini_mcu_pkg::SEL_W-1:0]   core_sel_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  core_dat_o,
  output logic                             core_ack_o,

  input  logic                             dbg_cyc_i,
  input  logic                             dbg_stb_i,
  input  logic                             dbg_we_i,
  input  logic [mini_mcu_pkg::ADDR_W-1:0]  dbg_adr_i,
  input  logic [mini_mcu_pkg::DATA_W-1:0]  dbg_dat_i,
  input  logic [mini_mcu_pkg::SEL_W-1:0]   dbg_sel_i,
  output logic [mini_mcu_pkg::DATA_W-1:0]  dbg_dat_o,
  output logic                             dbg_ack_o,

  output logic                             timer_irq_o,
  output logic                             tests_passed_o,
  output logic                             tests_failed_o,
  output logic [mini_mcu_pkg::DATA_W-1:0]  exit_value_o,
  output logic                             exit_valid_o
);

  import mini_mcu_pkg::*;

  logic              bus_stb;
  logic              bus_we;
  logic [ADDR_W-1:0] bus_adr;
  logic [DATA_W-1:0] bus_dat_w;
  logic [SEL_W-1:0]  bus_sel;
  logic [DATA_W-1:0] bus_dat_r;
  logic              bus_ack;

  logic              ram_stb;
  logic              tmr_stb;
  logic              exit_stb;
  logic [DATA_W-1:0] ram_dat;
  logic [DATA_W-1:0] tmr_dat;
  logic [DATA_W-1:0] exit_dat;
  logic              ram_ack;
  logic              tmr_ack;
  logic              exit_ack;

  bus_arbiter arbiter_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .core_cyc_i (core_cyc_i),
    .core_stb_i (core_stb_i),
    .core_we_i  (core_we_i),
    .core_adr_i (core_adr_i),
    .core_dat_i (core_dat_i),
    .core_sel_i (core_sel_i),
    .core_dat_o (core_dat_o),
    .core_ack_o (core_ack_o),
    .dbg_cyc_i  (dbg_cyc_i),
    .dbg_stb_i  (dbg_stb_i),
    .dbg_we_i   (dbg_we_i),
    .dbg_adr_i  (dbg_adr_i),
    .dbg_dat_i  (dbg_dat_i),
    .dbg_sel_i  (dbg_sel_i),
    .dbg_dat_o  (dbg_dat_o),
    .dbg_ack_o  (dbg_ack_o),
    // slaves qualify on the strobe alone, the arbiter already gates it with cyc
    .bus_cyc_o  (),
    .bus_stb_o  (bus_stb),
    .bus_we_o   (bus_we),
    .bus_adr_o  (bus_adr),
    .bus_dat_o  (bus_dat_w),
    .bus_sel_o  (bus_sel),
    .bus_dat_i  (bus_dat_r),
    .bus_ack_i  (bus_ack)
  );

  slave_decoder #(
    .RAM_WORDS (RAM_WORDS)
  ) decoder_i (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .bus_stb_i  (bus_stb),
    .bus_adr_i  (bus_adr),
    .bus_dat_o  (bus_dat_r),
    .bus_ack_o  (bus_ack),
    .ram_stb_o  (ram_stb),
    .tmr_stb_o  (tmr_stb),
    .exit_stb_o (exit_stb),
    .ram_dat_i  (ram_dat),
    .ram_ack_i  (ram_ack),
    .tmr_dat_i  (tmr_dat),
    .tmr_ack_i  (tmr_ack),
    .exit_dat_i (exit_dat),
    .exit_ack_i (exit_ack)
  );

  sram #(
    .RAM_WORDS (RAM_WORDS)
  ) ram_i (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .stb_i   (ram_stb),
    .we_i    (bus_we),
    .adr_i   (bus_adr),
    .dat_i   (bus_dat_w),
    .sel_i   (bus_sel),
    .dat_o   (ram_dat),
    .ack_o   (ram_ack)
  );

  timer_irq timer_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .stb_i       (tmr_stb),
    .we_i        (bus_we),
    .adr_i       (bus_adr),
    .dat_i       (bus_dat_w),
    .dat_o       (tmr_dat),
    .ack_o       (tmr_ack),
    .timer_irq_o (timer_irq_o)
  );

  exit_ctrl exit_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .stb_i          (exit_stb),
    .we_i           (bus_we),
    .adr_i          (bus_adr),
    .dat_i          (bus_dat_w),
    .dat_o          (exit_dat),
    .ack_o          (exit_ack),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o)
  );

endmodule

`default_nettype wire

// ==== dv/mcu_sva.sv ====
/*
  concurrent assertions bound into the subsystem top level
  one-cycle acks inside a live cycle, exclusive acks,
  exclusive verdict flags, quiet outputs after reset
*/
`timescale 1ns/1ps
`default_nettype none

module mcu_sva (
  input logic                    clk_i,
  input logic                    reset_i,
  input logic                    core_cyc_i,
  input logic                    core_stb_i,
  input logic                    core_ack_o,
  input logic                    dbg_cyc_i,
  input logic                    dbg_stb_i,
  input logic                    dbg_ack_o,
  input logic                    timer_irq_o,
  input logic                    tests_passed_o,
  input logic                    tests_failed_o,
  input logic                    exit_valid_o,
  input mini_mcu_pkg::arb_state_e arb_state_i
);

  import mini_mcu_pkg::*;

  core_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    core_ack_o |=> !core_ack_o)
    else $error("core ack lasted more than one cycle");

  core_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    core_ack_o |-> core_cyc_i && core_stb_i)
    else $error("core ack outside a core cycle");

  dbg_ack_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    dbg_ack_o |=> !dbg_ack_o)
    else $error("debug ack lasted more than one cycle");

  dbg_ack_in_cycle: assert property (@(posedge clk_i) disable iff (reset_i)
    dbg_ack_o |-> dbg_cyc_i && dbg_stb_i)
    else $error("debug ack outside a debug cycle");

  acks_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(core_ack_o && dbg_ack_o))
    else $error("core and debug acks at the same time");

  verdict_exclusive: assert property (@(posedge clk_i) disable iff (reset_i)
    !(tests_passed_o && tests_failed_o))
    else $error("pass and fail flags both set");

  // arbiter idle and every status output low once reset has been seen
  quiet_after_reset: assert property (@(posedge clk_i)
    reset_i |=> !core_ack_o && !dbg_ack_o && !timer_irq_o && !tests_passed_o
                && !tests_failed_o && !exit_valid_o && arb_state_i == ARB_IDLE)
    else $error("outputs not quiet after reset");

endmodule

bind core_v_mini_mcu mcu_sva i_sva (
  .clk_i          (clk_i),
  .reset_i        (reset_i),
  .core_cyc_i     (core_cyc_i),
  .core_stb_i     (core_stb_i),
  .core_ack_o     (core_ack_o),
  .dbg_cyc_i      (dbg_cyc_i),
  .dbg_stb_i      (dbg_stb_i),
  .dbg_ack_o      (dbg_ack_o),
  .timer_irq_o    (timer_irq_o),
  .tests_passed_o (tests_passed_o),
  .tests_failed_o (tests_failed_o),
  .exit_valid_o   (exit_valid_o),
  .arb_state_i    (arbiter_i.state_q)
);

`default_nettype wire

// ==== dv/tb_top.sv ====
/*
  testbench for the mini MCU subsystem
  clock and reset, one Wishbone driver task per master,
  reference RAM model with byte-select merging,
  six directed and random tests and the closing report
*/
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import mini_mcu_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int RAM_WORDS    = 256;
  localparam int NUM_TESTS    = 6;
  // the overlap test issues the most accesses
  localparam int MAX_ACCESSES = 64;
  localparam int STREAM_LEN   = 16;

  logic              clk_i;
  logic              reset_i;
  logic              core_cyc_i;
  logic              core_stb_i;
  logic              core_we_i;
  logic [ADDR_W-1:0] core_adr_i;
  logic [DATA_W-1:0] core_dat_i;
  logic [SEL_W-1:0]  core_sel_i;
  logic [DATA_W-1:0] core_dat_o;
  logic              core_ack_o;
  logic              dbg_cyc_i;
  logic              dbg_stb_i;
  logic              dbg_we_i;
  logic [ADDR_W-1:0] dbg_adr_i;
  logic [DATA_W-1:0] dbg_dat_i;
  logic [SEL_W-1:0]  dbg_sel_i;
  logic [DATA_W-1:0] dbg_dat_o;
  logic              dbg_ack_o;
  logic              timer_irq_o;
  logic              tests_passed_o;
  logic              tests_failed_o;
  logic [DATA_W-1:0] exit_value_o;
  logic              exit_valid_o;

  logic [DATA_W-1:0] model [RAM_WORDS];
  logic [7:0]        widx [STREAM_LEN];
  logic [31:0]       rand_state;
  int                grant_log [$];
  int                checks;
  int                test_errs;
  int                check_fails;
  int                tests_run;
  int                tests_bad;

  core_v_mini_mcu #(
    .RAM_WORDS (RAM_WORDS)
  ) i_dut (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .core_cyc_i     (core_cyc_i),
    .core_stb_i     (core_stb_i),
    .core_we_i      (core_we_i),
    .core_adr_i     (core_adr_i),
    .core_dat_i     (core_dat_i),
    .core_sel_i     (core_sel_i),
    .core_dat_o     (core_dat_o),
    .core_ack_o     (core_ack_o),
    .dbg_cyc_i      (dbg_cyc_i),
    .dbg_stb_i      (dbg_stb_i),
    .dbg_we_i       (dbg_we_i),
    .dbg_adr_i      (dbg_adr_i),
    .dbg_dat_i      (dbg_dat_i),
    .dbg_sel_i      (dbg_sel_i),
    .dbg_dat_o      (dbg_dat_o),
    .dbg_ack_o      (dbg_ack_o),
    .timer_irq_o    (timer_irq_o),
    .tests_passed_o (tests_passed_o),
    .tests_failed_o (tests_failed_o),
    .exit_value_o   (exit_value_o),
    .exit_valid_o   (exit_valid_o)
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // LCG with the classic 32-bit constants, upper bits are the useful ones
  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0] sel);
    logic [31:0] res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] word_addr(input logic [7:0] idx);
    return RAM_BASE + {22'b0, idx, 2'b00};
  endfunction

  task automatic idle_masters();
    core_cyc_i <= 1'b0;
    core_stb_i <= 1'b0;
    core_we_i  <= 1'b0;
    core_adr_i <= '0;
    core_dat_i <= '0;
    core_sel_i <= '0;
    dbg_cyc_i  <= 1'b0;
    dbg_stb_i  <= 1'b0;
    dbg_we_i   <= 1'b0;
    dbg_adr_i  <= '0;
    dbg_dat_i  <= '0;
    dbg_sel_i  <= '0;
  endtask

  task automatic apply_reset();
    idle_masters();
    reset_i <= 1'b1;
    repeat (8) @(posedge clk_i);
    reset_i <= 1'b0;
  endtask

  // one classic cycle, waits counts edges from the strobe to the seen ack
  task automatic core_access(input logic we, input logic [31:0] adr,
                             input logic [31:0] wdat, input logic [3:0] sel,
                             output logic [31:0] rdat, output int waits);
    waits = 0;
    @(posedge clk_i);
    core_cyc_i <= 1'b1;
    core_stb_i <= 1'b1;
    core_we_i  <= we;
    core_adr_i <= adr;
    core_dat_i <= wdat;
    core_sel_i <= sel;
    do begin
      @(posedge clk_i);
      waits++;
    end while (!core_ack_o);
    rdat = core_dat_o;
    grant_log.push_back(0);
    core_cyc_i <= 1'b0;
    core_stb_i <= 1'b0;
    core_we_i  <= 1'b0;
  endtask

  task automatic dbg_access(input logic we, input logic [31:0] adr,
                            input logic [31:0] wdat, input logic [3:0] sel,
                            output logic [31:0] rdat, output int waits);
    waits = 0;
    @(posedge clk_i);
    dbg_cyc_i <= 1'b1;
    dbg_stb_i <= 1'b1;
    dbg_we_i  <= we;
    dbg_adr_i <= adr;
    dbg_dat_i <= wdat;
    dbg_sel_i <= sel;
    do begin
      @(posedge clk_i);
      waits++;
    end while (!dbg_ack_o);
    rdat = dbg_dat_o;
    grant_log.push_back(1);
    dbg_cyc_i <= 1'b0;
    dbg_stb_i <= 1'b0;
    dbg_we_i  <= 1'b0;
  endtask

  task automatic check_value(input string sig, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
      test_errs++;
    end
  endtask

  task automatic check_bit(input string sig, input logic got, input logic exp);
    checks++;
    assert (got === exp) else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", sig, got, exp);
      test_errs++;
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      $display("test %0d %s: %0d errors", tests_run, name, test_errs);
      tests_bad++;
      check_fails += test_errs;
    end
    test_errs = 0;
  endtask

  initial begin
    #(NUM_TESTS * MAX_ACCESSES * 4 * CLK_PERIOD);
    $display("watchdog expired before all tests finished");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    logic [31:0] rd;
    logic [31:0] d;
    logic [31:0] r;
    logic [31:0] cmp;
    int          waits;
    clk_i       = 1'b0;
    rand_state  = 32'd78257;
    checks      = 0;
    test_errs   = 0;
    check_fails = 0;
    tests_run   = 0;
    tests_bad   = 0;
    apply_reset();

    // quiet outputs after reset and with no traffic
    for (int c = 0; c < 10; c++) begin
      @(posedge clk_i);
      check_bit("core_ack_o", core_ack_o, 1'b0);
      check_bit("dbg_ack_o", dbg_ack_o, 1'b0);
      check_bit("timer_irq_o", timer_irq_o, 1'b0);
      check_bit("tests_passed_o", tests_passed_o, 1'b0);
      check_bit("tests_failed_o", tests_failed_o, 1'b0);
      check_bit("exit_valid_o", exit_valid_o, 1'b0);
      check_value("exit_value_o", exit_value_o, '0);
    end
    finish_test("reset state");

    // full word first so every byte of the model is known
    for (int i = 0; i < STREAM_LEN; i++) begin
      r = next_rand();
      widx[i] = r[23:16];
      d = next_rand();
      core_access(1'b1, word_addr(widx[i]), d, 4'hF, rd, waits);
      model[widx[i]] = d;
      check_value("core ack latency", waits, 32'd2);
      d = next_rand();
      core_access(1'b1, word_addr(widx[i]), d, r[27:24], rd, waits);
      model[widx[i]] = merge_bytes(model[widx[i]], d, r[27:24]);
      check_value("core ack latency", waits, 32'd2);
    end
    for (int i = 0; i < STREAM_LEN; i++) begin
      dbg_access(1'b0, word_addr(widx[i]), '0, 4'hF, rd, waits);
      check_value("dbg_dat_o", rd, model[widx[i]]);
      check_value("dbg ack latency", waits, 32'd2);
    end
    finish_test("ram byte select");

    // core owns the low half of the RAM and debug the high half
    grant_log.delete();
    fork
      begin
        logic [31:0] cd;
        logic [31:0] crd;
        logic [7:0]  ci;
        int          cw;
        for (int i = 0; i < STREAM_LEN; i++) begin
          cd = next_rand();
          ci = {1'b0, cd[22:16]};
          core_access(1'b1, word_addr(ci), cd, 4'hF, crd, cw);
          model[ci] = cd;
          core_access(1'b0, word_addr(ci), '0, 4'hF, crd, cw);
          check_value("core_dat_o", crd, model[ci]);
        end
      end
      begin
        logic [31:0] dd;
        logic [31:0] drd;
        logic [7:0]  di;
        int          dw;
        for (int i = 0; i < STREAM_LEN; i++) begin
          dd = next_rand();
          di = {1'b1, dd[22:16]};
          dbg_access(1'b1, word_addr(di), dd, 4'hF, drd, dw);
          model[di] = dd;
          dbg_access(1'b0, word_addr(di), '0, 4'hF, drd, dw);
          check_value("dbg_dat_o", drd, model[di]);
        end
      end
    join
    // debug owned the last grant of the previous test, so core wins first
    check_value("first owner", grant_log[0], 32'd0);
    for (int i = 1; i < grant_log.size(); i++) begin
      assert (grant_log[i] != grant_log[i-1]) else begin
        $display("grant did not alternate at access %0d", i);
        test_errs++;
      end
    end
    finish_test("overlapping masters");

    core_access(1'b1, EXIT_BASE, TEST_PASS_CODE, 4'hF, rd, waits);
    check_bit("tests_passed_o", tests_passed_o, 1'b1);
    check_bit("tests_failed_o", tests_failed_o, 1'b0);
    apply_reset();
    d = next_rand();
    if (d == TEST_PASS_CODE) begin
      d = ~d;
    end
    core_access(1'b1, EXIT_BASE, d, 4'hF, rd, waits);
    check_bit("tests_passed_o", tests_passed_o, 1'b0);
    check_bit("tests_failed_o", tests_failed_o, 1'b1);
    d = next_rand();
    dbg_access(1'b1, EXIT_BASE + 32'd4, d, 4'hF, rd, waits);
    check_value("exit_value_o", exit_value_o, d);
    check_bit("exit_valid_o", exit_valid_o, 1'b1);
    @(posedge clk_i);
    check_bit("exit_valid_o", exit_valid_o, 1'b0);
    check_value("exit_value_o", exit_value_o, d);
    apply_reset();
    finish_test("exit controller");

    core_access(1'b0, TIMER_BASE, '0, 4'hF, rd, waits);
    cmp = rd + 32'd30;
    dbg_access(1'b1, TIMER_BASE + 32'd4, cmp, 4'hF, rd, waits);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    core_access(1'b0, TIMER_BASE + 32'd4, '0, 4'hF, rd, waits);
    check_value("timer compare", rd, cmp);
    do begin
      core_access(1'b0, TIMER_BASE, '0, 4'hF, rd, waits);
    end while (rd <= cmp);
    check_bit("timer_irq_o", timer_irq_o, 1'b1);
    dbg_access(1'b1, TIMER_BASE + 32'd4, 32'hFFFF_0000, 4'hF, rd, waits);
    check_bit("timer_irq_o", timer_irq_o, 1'b0);
    finish_test("timer interrupt");

    core_access(1'b0, 32'h3000_0000, '0, 4'hF, rd, waits);
    check_value("core_dat_o", rd, '0);
    check_value("core ack latency", waits, 32'd2);
    dbg_access(1'b0, TIMER_BASE + 32'h100, '0, 4'hF, rd, waits);
    check_value("dbg_dat_o", rd, '0);
    check_value("dbg ack latency", waits, 32'd2);
    finish_test("unmapped address");

    $display("tests run %0d, tests failed %0d, checks %0d, check failures %0d",
             tests_run, tests_bad, checks, check_fails);
    if (tests_bad == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
design/mini_mcu_pkg.sv
design/bus_arbiter.sv
design/slave_decoder.sv
design/sram.sv
design/timer_irq.sv
design/exit_ctrl.sv
design/core_v_mini_mcu.sv
dv/mcu_sva.sv
dv/tb_top.sv

// ==== Makefile ====
# Verilator flow for the mini MCU subsystem

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Some tests failed

SRCS := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation reported failure"; exit 1; \
	elif [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
